//--- int_execute_pkg.sv
// Integer execute shared types
`default_nettype none

package int_execute_pkg;

    // One lane value
    typedef logic [31:0] scalar_t;

    // Thread index for four threads
    localparam int THREAD_IDX_WIDTH = 2;
    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // Shift amounts come from the low bits of operand 2
    localparam int SHIFT_AMOUNT_WIDTH = 5;

    // Zero counts span 0 to 32
    localparam int COUNT_WIDTH = 6;

    // Lane operations. Codes not listed here produce zero
    typedef enum logic [4:0]
    {
        OP_OR       = 5'h00,
        OP_AND      = 5'h01,
        OP_XOR      = 5'h02,
        OP_ADD_I    = 5'h03,
        OP_SUB_I    = 5'h04,
        OP_MOVE     = 5'h05,
        OP_SHL      = 5'h06,
        OP_SHR      = 5'h07,
        OP_ASHR     = 5'h08,
        OP_CLZ      = 5'h09,
        OP_CTZ      = 5'h0a,
        OP_SEXT8    = 5'h0b,
        OP_SEXT16   = 5'h0c,
        OP_CMPEQ_I  = 5'h0d,
        OP_CMPNE_I  = 5'h0e,
        OP_CMPGT_I  = 5'h0f,
        OP_CMPGE_I  = 5'h10,
        OP_CMPLT_I  = 5'h11,
        OP_CMPLE_I  = 5'h12,
        OP_CMPGT_U  = 5'h13,
        OP_CMPGE_U  = 5'h14,
        OP_CMPLT_U  = 5'h15,
        OP_CMPLE_U  = 5'h16
    } alu_op_t;

    // Branch kinds
    typedef enum logic [2:0]
    {
        BRANCH_ZERO          = 3'd0,
        BRANCH_NOT_ZERO      = 3'd1,
        BRANCH_ALWAYS        = 3'd2,
        BRANCH_CALL_OFFSET   = 3'd3,
        BRANCH_CALL_REGISTER = 3'd4,
        BRANCH_REGISTER      = 3'd5
    } branch_type_t;

endpackage

`default_nettype wire

//--- bit_count.sv
// Leading and trailing zero counter
`default_nettype none

module bit_count
    import int_execute_pkg::*;
(
    input  scalar_t                value,
    output logic [COUNT_WIDTH-1:0] leading_zeros,
    output logic [COUNT_WIDTH-1:0] trailing_zeros
);

    // Leading zeros
    // Scan upward so the highest set bit is the last one to win
    always_comb
    begin
        leading_zeros = COUNT_WIDTH'(32);
        for (int i = 0; i < 32; i++)
        begin
            if (value[i])
            begin
                leading_zeros = COUNT_WIDTH'(31 - i);
            end
        end
    end

    // Trailing zeros
    // Scan downward so the lowest set bit wins
    always_comb
    begin
        trailing_zeros = COUNT_WIDTH'(32);
        for (int i = 31; i >= 0; i--)
        begin
            if (value[i])
            begin
                trailing_zeros = COUNT_WIDTH'(i);
            end
        end
    end

    // A count never exceeds the word width
    always_comb
    begin
        assert (leading_zeros <= COUNT_WIDTH'(32) && trailing_zeros <= COUNT_WIDTH'(32))
        else
            $error("bit_count: count out of range");
    end

endmodule

`default_nettype wire

//--- lane_alu.sv
// Integer ALU for one vector lane
`default_nettype none

module lane_alu
    import int_execute_pkg::*;
(
    input  alu_op_t alu_op,
    input  scalar_t operand1,
    input  scalar_t operand2,
    output scalar_t result
);

    scalar_t difference;
    logic borrow;
    logic negative;
    logic overflow;
    logic zero;
    logic signed_gtr;
    logic [SHIFT_AMOUNT_WIDTH-1:0] shift_amount;
    logic shift_in_sign;
    scalar_t rshift;
    logic [COUNT_WIDTH-1:0] lz;
    logic [COUNT_WIDTH-1:0] tz;

    // One subtractor serves subtract and every compare
    assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
    assign negative = difference[31];
    assign overflow = operand2[31] == negative && operand1[31] != operand2[31];
    assign zero = difference == 32'd0;
    assign signed_gtr = overflow == negative;

    // Right shifts where arithmetic fills with the sign of operand 1
    assign shift_amount = operand2[SHIFT_AMOUNT_WIDTH-1:0];
    assign shift_in_sign = alu_op == OP_ASHR ? operand1[31] : 1'b0;
    assign rshift = scalar_t'({{32{shift_in_sign}}, operand1} >> shift_amount);

    bit_count bit_count_inst
    (
        .value          (operand2),
        .leading_zeros  (lz),
        .trailing_zeros (tz)
    );

    always_comb
    begin
        case (alu_op)
            OP_OR:
                result = operand1 | operand2;
            OP_AND:
                result = operand1 & operand2;
            OP_XOR:
                result = operand1 ^ operand2;
            OP_ADD_I:
                result = operand1 + operand2;
            OP_SUB_I:
                result = difference;
            OP_MOVE:
                result = operand2;
            OP_SHL:
                result = operand1 << shift_amount;
            OP_SHR,
            OP_ASHR:
                result = rshift;
            OP_CLZ:
                result = scalar_t'(lz);
            OP_CTZ:
                result = scalar_t'(tz);
            OP_SEXT8:
                result = scalar_t'($signed(operand2[7:0]));
            OP_SEXT16:
                result = scalar_t'($signed(operand2[15:0]));

            // Compares give 0 or 1
            OP_CMPEQ_I:
                result = {31'd0, zero};
            OP_CMPNE_I:
                result = {31'd0, !zero};
            OP_CMPGT_I:
                result = {31'd0, signed_gtr && !zero};
            OP_CMPGE_I:
                result = {31'd0, signed_gtr || zero};
            OP_CMPLT_I:
                result = {31'd0, !signed_gtr && !zero};
            OP_CMPLE_I:
                result = {31'd0, !signed_gtr || zero};
            OP_CMPGT_U:
                result = {31'd0, !borrow && !zero};
            OP_CMPGE_U:
                result = {31'd0, !borrow || zero};
            OP_CMPLT_U:
                result = {31'd0, borrow && !zero};
            OP_CMPLE_U:
                result = {31'd0, borrow || zero};
            default:
                result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_stage.sv
// Execute stage one with lane ALUs
`default_nettype none

module alu_stage
    import int_execute_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                           clk,
    input  logic                           reset,

    // Incoming instruction
    input  logic                           instr_valid,
    input  alu_op_t                        alu_op,
    input  logic                           branch_en,
    input  branch_type_t                   branch_type,
    input  thread_idx_t                    thread_idx,
    input  scalar_t                        pc,
    input  scalar_t                        immediate,
    input  scalar_t [NUM_LANES-1:0]        operand1,
    input  scalar_t [NUM_LANES-1:0]        operand2,
    input  logic [NUM_LANES-1:0]           mask_value,

    // Rollback from writeback
    input  logic                           wb_rollback_en,
    input  thread_idx_t                    wb_rollback_thread_idx,

    // To branch stage
    output logic                           s1_valid,
    output scalar_t [NUM_LANES-1:0]        s1_result,
    output logic [NUM_LANES-1:0]           s1_mask_value,
    output thread_idx_t                    s1_thread_idx,
    output logic                           s1_branch_en,
    output branch_type_t                   s1_branch_type,
    output scalar_t                        s1_lane0_operand1,
    output scalar_t                        s1_pc,
    output scalar_t                        s1_immediate
);

    scalar_t [NUM_LANES-1:0] lane_result;
    logic squash;
    logic item_valid;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_alu_gen
            lane_alu lane_alu_inst
            (
                .alu_op   (alu_op),
                .operand1 (operand1[lane]),
                .operand2 (operand2[lane]),
                .result   (lane_result[lane])
            );
        end
    endgenerate

    // Drop the instruction while writeback rolls its thread back
    assign squash = wb_rollback_en && wb_rollback_thread_idx == thread_idx;
    assign item_valid = instr_valid && !squash;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= item_valid;
    end

    // Payload moves on even when squashed
    always_ff @(posedge clk)
    begin
        s1_result <= lane_result;
        s1_mask_value <= mask_value;
        s1_thread_idx <= thread_idx;
        s1_branch_en <= branch_en;
        s1_branch_type <= branch_type;
        s1_lane0_operand1 <= operand1[0];
        s1_pc <= pc;
        s1_immediate <= immediate;
    end

    squash_blocks_valid: assert property (@(posedge clk) disable iff (reset)
        (wb_rollback_en && wb_rollback_thread_idx == thread_idx) |=> !s1_valid)
    else
        $error("alu_stage: squashed instruction left stage valid");

endmodule

`default_nettype wire

//--- branch_stage.sv
// Execute stage two with branch resolution
`default_nettype none

module branch_stage
    import int_execute_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                           clk,
    input  logic                           reset,

    // From ALU stage
    input  logic                           s1_valid,
    input  scalar_t [NUM_LANES-1:0]        s1_result,
    input  logic [NUM_LANES-1:0]           s1_mask_value,
    input  thread_idx_t                    s1_thread_idx,
    input  logic                           s1_branch_en,
    input  branch_type_t                   s1_branch_type,
    input  scalar_t                        s1_lane0_operand1,
    input  scalar_t                        s1_pc,
    input  scalar_t                        s1_immediate,

    // To writeback
    output logic                           ix_instruction_valid,
    output scalar_t [NUM_LANES-1:0]        ix_result,
    output logic [NUM_LANES-1:0]           ix_mask_value,
    output thread_idx_t                    ix_thread_idx,
    output logic                           ix_rollback_en,
    output scalar_t                        ix_rollback_pc
);

    logic branch_taken;
    scalar_t rollback_target;

    // Conditional branches test only bit 0 of lane 0
    always_comb
    begin
        branch_taken = 1'b0;
        if (s1_branch_en)
        begin
            case (s1_branch_type)
                BRANCH_ZERO:
                    branch_taken = !s1_lane0_operand1[0];
                BRANCH_NOT_ZERO:
                    branch_taken = s1_lane0_operand1[0];
                default:
                    branch_taken = 1'b1;
            endcase
        end
    end

    // Register forms jump to lane 0 and everything else is pc relative
    always_comb
    begin
        case (s1_branch_type)
            BRANCH_CALL_REGISTER,
            BRANCH_REGISTER:
                rollback_target = s1_lane0_operand1;
            default:
                rollback_target = s1_pc + s1_immediate;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ix_instruction_valid <= 1'b0;
            ix_rollback_en <= 1'b0;
        end
        else
        begin
            ix_instruction_valid <= s1_valid;
            ix_rollback_en <= s1_valid && branch_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        ix_result <= s1_result;
        ix_mask_value <= s1_mask_value;
        ix_thread_idx <= s1_thread_idx;
        ix_rollback_pc <= rollback_target;
    end

    rollback_needs_valid: assert property (@(posedge clk) disable iff (reset)
        ix_rollback_en |-> ix_instruction_valid)
    else
        $error("branch_stage: rollback without a valid instruction");

endmodule

`default_nettype wire

//--- int_execute.sv
// Integer execute pipeline top
`default_nettype none

module int_execute
    import int_execute_pkg::*;
#(
    parameter int NUM_LANES = 4
)
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           instr_valid,
    input  alu_op_t                        alu_op,
    input  logic                           branch_en,
    input  branch_type_t                   branch_type,
    input  thread_idx_t                    thread_idx,
    input  scalar_t                        pc,
    input  scalar_t                        immediate,
    input  scalar_t [NUM_LANES-1:0]        operand1,
    input  scalar_t [NUM_LANES-1:0]        operand2,
    input  logic [NUM_LANES-1:0]           mask_value,
    input  logic                           wb_rollback_en,
    input  thread_idx_t                    wb_rollback_thread_idx,

    output logic                           ix_instruction_valid,
    output scalar_t [NUM_LANES-1:0]        ix_result,
    output logic [NUM_LANES-1:0]           ix_mask_value,
    output thread_idx_t                    ix_thread_idx,
    output logic                           ix_rollback_en,
    output scalar_t                        ix_rollback_pc
);

    // Stage one to stage two
    logic                    s1_valid;
    scalar_t [NUM_LANES-1:0] s1_result;
    logic [NUM_LANES-1:0]    s1_mask_value;
    thread_idx_t             s1_thread_idx;
    logic                    s1_branch_en;
    branch_type_t            s1_branch_type;
    scalar_t                 s1_lane0_operand1;
    scalar_t                 s1_pc;
    scalar_t                 s1_immediate;

    alu_stage #(.NUM_LANES(NUM_LANES)) alu_stage_inst
    (
        .clk                    (clk),
        .reset                  (reset),
        .instr_valid            (instr_valid),
        .alu_op                 (alu_op),
        .branch_en              (branch_en),
        .branch_type            (branch_type),
        .thread_idx             (thread_idx),
        .pc                     (pc),
        .immediate              (immediate),
        .operand1               (operand1),
        .operand2               (operand2),
        .mask_value             (mask_value),
        .wb_rollback_en         (wb_rollback_en),
        .wb_rollback_thread_idx (wb_rollback_thread_idx),
        .s1_valid               (s1_valid),
        .s1_result              (s1_result),
        .s1_mask_value          (s1_mask_value),
        .s1_thread_idx          (s1_thread_idx),
        .s1_branch_en           (s1_branch_en),
        .s1_branch_type         (s1_branch_type),
        .s1_lane0_operand1      (s1_lane0_operand1),
        .s1_pc                  (s1_pc),
        .s1_immediate           (s1_immediate)
    );

    branch_stage #(.NUM_LANES(NUM_LANES)) branch_stage_inst
    (
        .clk                  (clk),
        .reset                (reset),
        .s1_valid             (s1_valid),
        .s1_result            (s1_result),
        .s1_mask_value        (s1_mask_value),
        .s1_thread_idx        (s1_thread_idx),
        .s1_branch_en         (s1_branch_en),
        .s1_branch_type       (s1_branch_type),
        .s1_lane0_operand1    (s1_lane0_operand1),
        .s1_pc                (s1_pc),
        .s1_immediate         (s1_immediate),
        .ix_instruction_valid (ix_instruction_valid),
        .ix_result            (ix_result),
        .ix_mask_value        (ix_mask_value),
        .ix_thread_idx        (ix_thread_idx),
        .ix_rollback_en       (ix_rollback_en),
        .ix_rollback_pc       (ix_rollback_pc)
    );

endmodule

`default_nettype wire

//--- int_execute_tb.sv
// Integer execute testbench
`default_nettype none

module int_execute_tb
    import int_execute_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_VECTORS = 26;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + 10;

    // Word layout of one vector in the pattern file
    localparam int VEC_WORDS = 17;
    localparam int W_PC = 1;
    localparam int W_IMM = 2;
    localparam int W_OP1 = 3;
    localparam int W_OP2 = 7;
    localparam int W_EXP = 11;
    localparam int W_RES = 12;
    localparam int W_RPC = 16;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    alu_op_t                 alu_op;
    logic                    branch_en;
    branch_type_t            branch_type;
    thread_idx_t             thread_idx;
    scalar_t                 pc;
    scalar_t                 immediate;
    scalar_t [NUM_LANES-1:0] operand1;
    scalar_t [NUM_LANES-1:0] operand2;
    logic [NUM_LANES-1:0]    mask_value;
    logic                    wb_rollback_en;
    thread_idx_t             wb_rollback_thread_idx;
    logic                    ix_instruction_valid;
    scalar_t [NUM_LANES-1:0] ix_result;
    logic [NUM_LANES-1:0]    ix_mask_value;
    thread_idx_t             ix_thread_idx;
    logic                    ix_rollback_en;
    scalar_t                 ix_rollback_pc;

    logic [31:0] patterns [NUM_VECTORS*VEC_WORDS];
    int cycle_count = 0;

    int_execute #(.NUM_LANES(NUM_LANES)) int_execute_inst
    (
        .clk                    (clk),
        .reset                  (reset),
        .instr_valid            (instr_valid),
        .alu_op                 (alu_op),
        .branch_en              (branch_en),
        .branch_type            (branch_type),
        .thread_idx             (thread_idx),
        .pc                     (pc),
        .immediate              (immediate),
        .operand1               (operand1),
        .operand2               (operand2),
        .mask_value             (mask_value),
        .wb_rollback_en         (wb_rollback_en),
        .wb_rollback_thread_idx (wb_rollback_thread_idx),
        .ix_instruction_valid   (ix_instruction_valid),
        .ix_result              (ix_result),
        .ix_mask_value          (ix_mask_value),
        .ix_thread_idx          (ix_thread_idx),
        .ix_rollback_en         (ix_rollback_en),
        .ix_rollback_pc         (ix_rollback_pc)
    );

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        instr_valid = 1'b0;
        alu_op = OP_OR;
        branch_en = 1'b0;
        branch_type = BRANCH_ZERO;
        thread_idx = '0;
        pc = '0;
        immediate = '0;
        operand1 = '0;
        operand2 = '0;
        mask_value = '0;
        wb_rollback_en = 1'b0;
        wb_rollback_thread_idx = '0;
    endtask

    task automatic drive_vector(input int idx);
        logic [31:0] ctrl;
        int base;
        int lane;
        base = idx * VEC_WORDS;
        ctrl = patterns[base];
        instr_valid = ctrl[28];
        alu_op = alu_op_t'(ctrl[24:20]);
        branch_en = ctrl[19];
        branch_type = branch_type_t'(ctrl[18:16]);
        thread_idx = ctrl[13:12];
        mask_value = ctrl[8 +: NUM_LANES];
        wb_rollback_en = ctrl[4];
        wb_rollback_thread_idx = ctrl[1:0];
        pc = patterns[base + W_PC];
        immediate = patterns[base + W_IMM];
        for (lane = 0; lane < NUM_LANES; lane++)
        begin
            operand1[lane] = patterns[base + W_OP1 + lane];
            operand2[lane] = patterns[base + W_OP2 + lane];
        end
    endtask

    // Payload matters only for a valid item and the target only when taken
    task automatic check_vector(input int idx);
        logic [31:0] expect_ctrl;
        int base;
        int lane;
        string tag;
        base = idx * VEC_WORDS;
        expect_ctrl = patterns[base + W_EXP];
        tag = $sformatf("vector %0d", idx);
        check_value({tag, " valid"}, 32'(expect_ctrl[15:12]), 32'(ix_instruction_valid));
        check_value({tag, " rollback_en"}, 32'(expect_ctrl[3:0]), 32'(ix_rollback_en));
        if (expect_ctrl[12])
        begin
            check_value({tag, " mask"}, 32'(expect_ctrl[11:8]), 32'(ix_mask_value));
            check_value({tag, " thread"}, 32'(expect_ctrl[7:4]), 32'(ix_thread_idx));
            for (lane = 0; lane < NUM_LANES; lane++)
            begin
                check_value($sformatf("%s result lane %0d", tag, lane),
                            patterns[base + W_RES + lane], ix_result[lane]);
            end
            if (expect_ctrl[0])
                check_value({tag, " rollback_pc"}, patterns[base + W_RPC], ix_rollback_pc);
        end
    endtask

    initial
    begin
        $readmemh("int_execute_patterns.hex", patterns);
        clk = 1'b0;
        reset = 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Each vector shows up on the outputs two edges after it is driven
        for (int c = 0; c < NUM_VECTORS + 2; c++)
        begin
            @(posedge clk);
            #1;
            if (c >= 2)
                check_vector(c - 2);
            if (c < NUM_VECTORS)
                drive_vector(c);
            else
                drive_idle();
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- int_execute.f
int_execute_pkg.sv
bit_count.sv
lane_alu.sv
alu_stage.sv
branch_stage.sv
int_execute.sv
int_execute_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the integer execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f int_execute.f \
    --top-module int_execute_tb -o int_execute_sim
then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/int_execute_sim)
then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$output"
if echo "$output" | grep -qx "Testbench passed"
then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- int_execute_patterns.hex
// ctrl {valid, op[7:0], br_en|br_type, thread, mask, rb_en, rb_thread}, pc, imm, op1 lanes 0-3, op2 lanes 0-3
// expect {valid, mask, thread, rollback_en}, result lanes 0-3, rollback_pc
// Logic, arithmetic and move with branch variants
10008f00 100 20 ffff 12345678 0 f0f0f0f0 ffff0000 87654321 0 f0f0f0f 1f00 ffffffff 97755779 0 ffffffff 0
10191500 200 40 ffffffff 12345678 aaaaaaaa f0f0f0f0 ffff 87654321 55555555 ff00ff00 1511 ffff 2244220 0 f000f000 240
102d2a00 300 10 1000 12345678 aaaaaaaa 0 ffff 87654321 55555555 0 1a21 efff 95511559 ffffffff 0 1000
10303f00 0 0 1 ffffffff 7fffffff 12345678 2 1 1 11111111 1f30 3 0 80000000 23456789 0
10480f00 400 fffffff0 4 0 80000000 12345678 3 1 1 12345678 1f01 1 ffffffff 7fffffff 0 3f0
105c1300 500 8 11111111 22222222 33333333 44444444 deadbeef 0 ffffffff badf00d 1311 deadbeef 0 ffffffff badf00d 11111111
// Shifts, counts and sign extension
106a2f00 600 100 1 1 80000001 12345678 4 1f 21 0 1f21 10 80000000 2 12345678 700
10793f00 700 4 80000000 80000000 ffffffff 12345678 1f 4 20 8 1f30 1 8000000 ffffffff 123456 0
108b0f00 800 24 80000000 80000000 7fffffff f0000000 1f 4 4 3c 1f01 ffffffff f8000000 7ffffff ffffffff 824
10951f00 900 4 ffffffff ffffffff ffffffff ffffffff 0 1 80000000 10000 1f10 20 1f 0 f 0
10a02f00 0 0 0 0 0 0 0 1 80000000 10000 1f20 20 0 1f 10 0
10b03f11 0 0 0 0 0 0 7f 80 123456ff ffffff00 1f30 7f ffffff80 ffffffff 0 0
10c00f00 0 0 0 0 0 0 7fff 8000 1234abcd ffff0001 1f00 7fff ffff8000 ffffabcd 1 0
// Compares, lanes are equal, min vs max signed, -1 vs 1, 1 vs -1
10d01f00 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1f10 1 0 0 0 0
10e02e00 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1e20 0 1 1 1 0
10f03d00 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1d30 0 0 0 1 0
11000c00 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1c00 1 0 0 1 0
11101b00 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1b10 0 1 1 0 0
11202900 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1920 1 1 1 0 0
11303700 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1730 0 1 1 0 0
11400600 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1600 1 1 1 0 0
11501100 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1110 0 0 0 1 0
11602800 0 0 5 80000000 ffffffff 1 5 7fffffff 1 ffffffff 1820 1 0 0 1 0
// Squash, idle branch, then a pass-through with another thread rolling back
100a2f12 900 4 0 0 0 0 0 0 0 0 0000 0 0 0 0 0
003a0f00 0 0 0 0 0 0 0 0 0 0 0000 0 0 0 0 0
10382911 1000 0 0 1 2 3 10 20 30 40 1921 10 21 32 43 1000
